//--- Makefile
VERILATOR ?= verilator
TOP       ?= blackjackTb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "=== FAIL ===" $(LOG); then exit 1; fi

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- project.f
+incdir+rtl
rtl/blackjackPkg.sv
rtl/cardDeck.sv
rtl/blackjackTable.sv
rtl/scoreDisplay.sv
rtl/blackjackTop.sv
testbench/blackjackTable_checker.sv
testbench/blackjackTb.sv

//--- rtl/blackjackPkg.sv
`include "blackjack_defines.svh"

package blackjackPkg;

    typedef logic [`CARD_WIDTH-1:0] cardValue_t;    // 1 to 10.
    typedef logic [`TOTAL_WIDTH-1:0] handTotal_t;

    typedef struct packed {
        handTotal_t player;
        handTotal_t dealer;
    } handTotals_t;

    typedef enum logic [1:0] {
        verdictNone,
        verdictWin,
        verdictLoss,
        verdictPush
    } verdict_t;

    typedef enum logic [3:0] {
        idle,
        dealPlayerFirst,
        dealDealerFirst,
        dealDealerSecond,
        dealPlayerSecond,
        playerTurn,
        playerHit,
        dealerTurn,
        dealerHit,
        settle,
        verdictHold
    } tableState_t;

    // active low, common anode.
    typedef struct packed {
        logic [`SEGMENT_WIDTH-1:0] tens;
        logic [`SEGMENT_WIDTH-1:0] ones;
    } digitPair_t;

endpackage

//--- rtl/blackjackTable.sv
`timescale 1ns/10ps
`include "blackjack_defines.svh"

module blackjackTable (
    input  logic                      clock,
    input  logic                      resetar,
    input  logic                      hitCard,
    input  logic                      standHand,
    input  logic                      deckReady,
    input  blackjackPkg::cardValue_t  topCard,
    output logic                      dealCard,
    output logic                      tableReady,
    output blackjackPkg::verdict_t    verdict,
    output blackjackPkg::handTotals_t shownTotals
);
    import blackjackPkg::*;

    tableState_t state;
    tableState_t nextState;
    handTotal_t  playerTotal;
    handTotal_t  dealerTotal;
    verdict_t    settleResult;
    logic        toPlayer;
    logic        toDealer;

    assign toPlayer = (state == dealPlayerFirst) || (state == dealPlayerSecond) ||
                      (state == playerHit);
    assign toDealer = (state == dealDealerFirst) || (state == dealDealerSecond) ||
                      (state == dealerHit);
    assign dealCard = toPlayer || toDealer;

    assign tableReady = (state == idle) && deckReady;

    assign shownTotals.player = playerTotal;
    assign shownTotals.dealer = (state == verdictHold) ? dealerTotal : '0;  // hidden until verdict.

    // rules are checked in order, first match wins.
    always_comb begin
        if (playerTotal > `BUST_LIMIT) begin
            settleResult = verdictLoss;
        end else if (dealerTotal > `BUST_LIMIT) begin
            settleResult = verdictWin;
        end else if (playerTotal > dealerTotal) begin
            settleResult = verdictWin;
        end else if (playerTotal < dealerTotal) begin
            settleResult = verdictLoss;
        end else begin
            settleResult = verdictPush;
        end
    end

    always_comb begin
        nextState = state;
        case (state)
            idle: begin
                if (deckReady) begin
                    nextState = dealPlayerFirst;
                end
            end
            dealPlayerFirst:  nextState = dealDealerFirst;
            dealDealerFirst:  nextState = dealDealerSecond;
            dealDealerSecond: nextState = dealPlayerSecond;
            dealPlayerSecond: nextState = playerTurn;
            playerTurn: begin
                if (playerTotal > `BUST_LIMIT) begin
                    nextState = verdictHold;
                end else if (hitCard) begin
                    nextState = playerHit;
                end else if (standHand) begin
                    nextState = dealerTurn;
                end
            end
            playerHit: nextState = playerTurn;
            dealerTurn: begin
                if (dealerTotal < `DEALER_STAND) begin
                    nextState = dealerHit;
                end else begin
                    nextState = settle;
                end
            end
            dealerHit:   nextState = dealerTurn;
            settle:      nextState = verdictHold;
            verdictHold: nextState = verdictHold;  // held until resetar.
            default:     nextState = idle;
        endcase
    end

    always_ff @(posedge clock) begin
        if (resetar) begin
            state       <= idle;
            playerTotal <= '0;
            dealerTotal <= '0;
            verdict     <= verdictNone;
        end else begin
            state <= nextState;
            if (toPlayer) begin
                playerTotal <= playerTotal + handTotal_t'(topCard);
            end
            if (toDealer) begin
                dealerTotal <= dealerTotal + handTotal_t'(topCard);
            end
            if (state == playerTurn && playerTotal > `BUST_LIMIT) begin
                verdict <= verdictLoss;  // bust, dealer never draws.
            end else if (state == settle) begin
                verdict <= settleResult;
            end
        end
    end

endmodule

//--- rtl/blackjackTop.sv
`timescale 1ns/10ps

module blackjackTop (
    input  logic                     clock,
    input  logic                     resetar,
    input  logic                     hitCard,
    input  logic                     standHand,
    output logic                     tableReady,
    output logic                     winLed,
    output logic                     lossLed,
    output logic                     pushLed,
    output blackjackPkg::digitPair_t playerDigits,
    output blackjackPkg::digitPair_t dealerDigits
);
    import blackjackPkg::*;

    cardValue_t  topCard;
    logic        deckReady;
    logic        dealCard;
    verdict_t    verdict;
    handTotals_t shownTotals;

    cardDeck deck (
        .clock     (clock),
        .resetar   (resetar),
        .dealCard  (dealCard),
        .topCard   (topCard),
        .deckReady (deckReady)
    );

    blackjackTable table0 (
        .clock       (clock),
        .resetar     (resetar),
        .hitCard     (hitCard),
        .standHand   (standHand),
        .deckReady   (deckReady),
        .topCard     (topCard),
        .dealCard    (dealCard),
        .tableReady  (tableReady),
        .verdict     (verdict),
        .shownTotals (shownTotals)
    );

    scoreDisplay playerDisplay (.total(shownTotals.player), .digits(playerDigits));
    scoreDisplay dealerDisplay (.total(shownTotals.dealer), .digits(dealerDigits));

    assign winLed  = (verdict == verdictWin);
    assign lossLed = (verdict == verdictLoss);
    assign pushLed = (verdict == verdictPush);

endmodule

//--- rtl/blackjack_defines.svh
`ifndef BLACKJACK_DEFINES_SVH
`define BLACKJACK_DEFINES_SVH

// deck geometry.
`define DECK_SIZE       52
`define RANKS_PER_SUIT  13

// datapath widths.
`define CARD_WIDTH      4
`define INDEX_WIDTH     6
`define TOTAL_WIDTH     7
`define SEGMENT_WIDTH   7

// game limits.
`define DEALER_STAND    17
`define BUST_LIMIT      21

// power-up state of the shuffle lfsr, never zero.
`define LFSR_SEED       6'b001011

`endif

//--- rtl/cardDeck.sv
`timescale 1ns/10ps
`include "blackjack_defines.svh"

module cardDeck (
    input  logic                     clock,
    input  logic                     resetar,
    input  logic                     dealCard,
    output blackjackPkg::cardValue_t topCard,
    output logic                     deckReady
);
    import blackjackPkg::*;

    cardValue_t deck [`DECK_SIZE];

    logic [`INDEX_WIDTH-1:0] shuffleIndex;
    logic [`INDEX_WIDTH-1:0] dealPointer;
    logic [`INDEX_WIDTH-1:0] partner;
    logic [`INDEX_WIDTH-1:0] lfsr = `LFSR_SEED;  // survives resetar, so each game differs.

    function automatic cardValue_t rankValue(input int position);
        int rank;
        rank = position % `RANKS_PER_SUIT;
        if (rank < 9) begin
            return cardValue_t'(rank + 1);
        end
        return cardValue_t'(10);  // ten and face cards.
    endfunction

    // fold lfsr values 52..63 back into the deck.
    assign partner = (lfsr < `DECK_SIZE) ? lfsr : lfsr - `INDEX_WIDTH'(`DECK_SIZE);

    assign topCard = deck[dealPointer];

    always_ff @(posedge clock) begin
        if (resetar) begin
            for (int i = 0; i < `DECK_SIZE; i++) begin
                deck[i] <= rankValue(i);
            end
        end else if (!deckReady) begin
            deck[shuffleIndex] <= deck[partner];
            deck[partner]      <= deck[shuffleIndex];
        end
    end

    always_ff @(posedge clock) begin
        if (!resetar && !deckReady) begin
            lfsr <= {lfsr[4:0], lfsr[5] ^ lfsr[4]};
        end
    end

    always_ff @(posedge clock) begin
        if (resetar) begin
            shuffleIndex <= '0;
            deckReady    <= 1'b0;
            dealPointer  <= '0;
        end else begin
            if (!deckReady) begin
                shuffleIndex <= shuffleIndex + 1'b1;
                if (shuffleIndex == `INDEX_WIDTH'(`DECK_SIZE - 1)) begin
                    deckReady <= 1'b1;  // last swap.
                end
            end
            if (dealCard) begin
                dealPointer <= dealPointer + 1'b1;
            end
        end
    end

endmodule

//--- rtl/scoreDisplay.sv
`timescale 1ns/10ps
`include "blackjack_defines.svh"

module scoreDisplay (
    input  blackjackPkg::handTotal_t total,
    output blackjackPkg::digitPair_t digits
);
    import blackjackPkg::*;

    handTotal_t tensValue;
    handTotal_t onesValue;

    function automatic logic [`SEGMENT_WIDTH-1:0] segmentPattern(input handTotal_t digit);
        case (digit)
            7'd0:    return 7'b1000000;
            7'd1:    return 7'b1111001;
            7'd2:    return 7'b0100100;
            7'd3:    return 7'b0110000;
            7'd4:    return 7'b0011001;
            7'd5:    return 7'b0010010;
            7'd6:    return 7'b0000010;
            7'd7:    return 7'b1111000;
            7'd8:    return 7'b0000000;
            7'd9:    return 7'b0010000;
            default: return 7'b1111111;
        endcase
    endfunction

    assign tensValue = total / 7'd10;
    assign onesValue = total % 7'd10;

    always_comb begin
        if (total > 7'd99) begin
            digits.tens = '1;  // all segments off.
            digits.ones = '1;
        end else begin
            digits.tens = segmentPattern(tensValue);
            digits.ones = segmentPattern(onesValue);
        end
    end

endmodule

//--- testbench/blackjackTable_checker.sv
`timescale 1ns/10ps

module tableAssertions (
    input logic                      clock,
    input logic                      resetar,
    input logic                      deckReady,
    input logic                      dealCard,
    input blackjackPkg::tableState_t state,
    input blackjackPkg::verdict_t    verdict,
    input blackjackPkg::handTotals_t shownTotals
);
    import blackjackPkg::*;

    // a single verdict, present only while the table holds it.
    oneVerdict: assert property (@(posedge clock) disable iff (resetar)
        (verdict != verdictNone) == (state == verdictHold))
        else $error("verdict active outside the verdict state");

    dealNeedsDeck: assert property (@(posedge clock) disable iff (resetar)
        dealCard |-> deckReady)
        else $error("card dealt before the shuffle finished");

    // dealer total stays hidden until the verdict.
    dealerHidden: assert property (@(posedge clock) disable iff (resetar)
        (verdict == verdictNone) |-> (shownTotals.dealer == '0))
        else $error("dealer total shown before a verdict");

    verdictHeld: assert property (@(posedge clock)
        (verdict != verdictNone && !resetar) |=> $stable(verdict))
        else $error("verdict changed without a reset");

endmodule

bind blackjackTable tableAssertions tableChecks (
    .clock       (clock),
    .resetar     (resetar),
    .deckReady   (deckReady),
    .dealCard    (dealCard),
    .state       (state),
    .verdict     (verdict),
    .shownTotals (shownTotals)
);

//--- testbench/blackjackTb.sv
`timescale 1ns/10ps
`include "blackjack_defines.svh"

module blackjackTb;
    import blackjackPkg::*;

    localparam int gameCount  = 20;
    localparam int cycleLimit = gameCount * (8 + 52 + 200);

    // active low, common anode, digits 0 to 9.
    localparam logic [`SEGMENT_WIDTH-1:0] segmentTable [10] = '{
        7'b1000000, 7'b1111001, 7'b0100100, 7'b0110000, 7'b0011001,
        7'b0010010, 7'b0000010, 7'b1111000, 7'b0000000, 7'b0010000
    };

    logic       clock = 1'b0;
    logic       resetar;
    logic       hitCard;
    logic       standHand;
    logic       tableReady;
    logic       winLed;
    logic       lossLed;
    logic       pushLed;
    digitPair_t playerDigits;
    digitPair_t dealerDigits;

    int unsigned             lcgState = 80;
    logic [`INDEX_WIDTH-1:0] modelLfsr = `LFSR_SEED;  // never reset, same as the deck.
    int                      modelDeck [`DECK_SIZE];
    int                      dealIndex;
    int                      checkCount = 0;
    int                      errorCount = 0;
    int                      cycleCount = 0;

    blackjackTop UUT (.*);

    always #2 clock = ~clock;

    always @(posedge clock) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount == cycleLimit) begin
            $display("timeout: the games did not finish within %0d cycles", cycleLimit);
            errorCount = errorCount + 1;
            finishRun();
        end
    end

    function automatic int nextRandom();
        lcgState = lcgState * 1103515245 + 12345;
        return int'(lcgState >> 16);
    endfunction

    function automatic digitPair_t expectedDigits(input int total);
        return {segmentTable[4'(total / 10)], segmentTable[4'(total % 10)]};
    endfunction

    // first matching rule decides.
    function automatic verdict_t settleRules(input int player, input int dealer);
        if (player > `BUST_LIMIT) return verdictLoss;
        if (dealer > `BUST_LIMIT) return verdictWin;
        if (player > dealer) return verdictWin;
        if (player < dealer) return verdictLoss;
        return verdictPush;
    endfunction

    function automatic verdict_t ledVerdict();
        if (winLed) return verdictWin;
        if (lossLed) return verdictLoss;
        if (pushLed) return verdictPush;
        return verdictNone;
    endfunction

    function automatic bit wantsHit(input int total);
        int roll;
        roll = nextRandom() % 8;
        if (total < 12) return roll != 0;
        if (total < `DEALER_STAND) return roll < 5;
        return roll == 0;  // the odd risky hit, to reach busts.
    endfunction

    function automatic int drawCard();
        dealIndex++;
        return modelDeck[dealIndex - 1];
    endfunction

    task automatic checkDigits(input digitPair_t got, input digitPair_t want, input string what);
        checkCount++;
        if (got !== want) begin
            errorCount++;
            $display("Fail at %0t ns: %s shows %h, expected %h", $time, what, got, want);
        end
    endtask

    task automatic checkVerdict(input verdict_t got, input verdict_t want, input string what);
        checkCount++;
        if (got !== want) begin
            errorCount++;
            $display("Fail at %0t ns: %s is %s, expected %s", $time, what, got.name(), want.name());
        end
    endtask

    task automatic checkReady(input logic got, input logic want, input string what);
        checkCount++;
        if (got !== want) begin
            errorCount++;
            $display("Fail at %0t ns: %s is %b, expected %b", $time, what, got, want);
        end
    endtask

    task automatic shuffleModel();
        int partner;
        int held;
        for (int i = 0; i < `DECK_SIZE; i++) begin
            modelDeck[i] = (i % `RANKS_PER_SUIT < 9) ? i % `RANKS_PER_SUIT + 1 : 10;
        end
        for (int i = 0; i < `DECK_SIZE; i++) begin
            partner = int'(modelLfsr);
            if (partner >= `DECK_SIZE) begin
                partner = partner - `DECK_SIZE;
            end
            held = modelDeck[i];
            modelDeck[i] = modelDeck[partner];
            modelDeck[partner] = held;
            modelLfsr = {modelLfsr[4:0], modelLfsr[5] ^ modelLfsr[4]};
        end
        dealIndex = 0;
    endtask

    task automatic applyReset();
        @(posedge clock);
        resetar <= 1'b1;
        repeat (8) @(posedge clock);
        resetar <= 1'b0;
        @(negedge clock);
        checkVerdict(ledVerdict(), verdictNone, "LEDs after reset");
        checkDigits(playerDigits, expectedDigits(0), "player after reset");
        checkDigits(dealerDigits, expectedDigits(0), "dealer after reset");
        checkReady(tableReady, 1'b0, "tableReady after reset");
    endtask

    // a stand is followed by a hit that the dealer turn must drop.
    task automatic pulseAfterGap(input bit hit);
        repeat (nextRandom() % 4) @(posedge clock);
        @(posedge clock);
        hitCard   <= hit;
        standHand <= !hit;
        @(posedge clock);
        hitCard   <= !hit;
        standHand <= 1'b0;
        @(posedge clock);
        hitCard   <= 1'b0;
        @(negedge clock);
    endtask

    task automatic waitVerdict(output bit seen);
        seen = 1'b0;
        for (int k = 0; k < 100 && !seen; k++) begin
            @(negedge clock);
            seen = winLed || lossLed || pushLed;
        end
        if (!seen) begin
            errorCount++;
            $display("no verdict LED came on within 100 cycles at %0t ns", $time);
        end
    endtask

    task automatic playGame(input int game);
        int       playerTotal;
        int       dealerTotal;
        int       firstError;
        bit       midReset;
        bit       seen;
        verdict_t want;
        firstError = errorCount;
        midReset = (game == 5) || (game == 13);
        applyReset();
        shuffleModel();
        for (int k = 1; k <= `DECK_SIZE; k++) begin
            @(negedge clock);
            checkReady(tableReady, k == `DECK_SIZE, "tableReady during shuffle");
        end
        repeat (5) @(posedge clock);  // leave idle, then four deals.
        @(negedge clock);
        playerTotal = drawCard();
        dealerTotal = drawCard();
        dealerTotal = dealerTotal + drawCard();
        playerTotal = playerTotal + drawCard();
        checkDigits(playerDigits, expectedDigits(playerTotal), "player after deal");
        checkDigits(dealerDigits, expectedDigits(0), "dealer after deal");
        while (playerTotal <= `BUST_LIMIT && wantsHit(playerTotal)) begin
            pulseAfterGap(1'b1);
            playerTotal = playerTotal + drawCard();
            checkDigits(playerDigits, expectedDigits(playerTotal), "player after hit");
            if (midReset) break;
        end
        if (midReset) begin
            $display("game %0d: reset in mid game at player %0d, %0d errors",
                     game, playerTotal, errorCount - firstError);
            return;
        end
        if (playerTotal <= `BUST_LIMIT) begin
            pulseAfterGap(1'b0);
            while (dealerTotal < `DEALER_STAND) begin
                dealerTotal = dealerTotal + drawCard();
            end
        end
        want = settleRules(playerTotal, dealerTotal);
        waitVerdict(seen);
        if (seen) begin
            checkVerdict(ledVerdict(), want, "verdict LEDs");
            checkDigits(playerDigits, expectedDigits(playerTotal), "player at verdict");
            checkDigits(dealerDigits, expectedDigits(dealerTotal), "dealer at verdict");
        end
        $display("game %0d: player %0d dealer %0d %s, %0d errors",
                 game, playerTotal, dealerTotal, want.name(), errorCount - firstError);
    endtask

    task automatic finishRun();
        $display("%0d checks, %0d errors", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    endtask

    initial begin
        resetar   <= 1'b1;
        hitCard   <= 1'b0;
        standHand <= 1'b0;
        for (int game = 0; game < gameCount; game++) begin
            playGame(game);
        end
        finishRun();
    end

endmodule
